//--- include/pins_config.svh
/* Bus sizes are fixed by the CPU. PINS_MAX_WAIT only bounds how long a testbench
   waits on a stalled bus; the controller itself never times out. */
`ifndef PINS_CONFIG_SVH
`define PINS_CONFIG_SVH

// --------------------
// Bus widths
// --------------------
`define PINS_ADDR_W   16        // Address pins A15..A0
`define PINS_DATA_W   8         // Data pins D7..D0

// --------------------
// Wait states
// --------------------
// Number of Tw cycles after which the bus counts as hung
`define PINS_MAX_WAIT 16

`endif

//--- rtl/pins_bus_pkg.sv
/* Address and data types seen on the external pins. The io view assumes the
   address splits into two data-width bytes. */
package pins_bus_pkg;

    `include "pins_config.svh"

    // --------------------
    // Data
    // --------------------
    typedef logic [`PINS_DATA_W-1:0] data_t;    // One byte on D7..D0

    // --------------------
    // Address word
    // --------------------
    // I/O cycles put the port number on A7..A0 and an extra byte on A15..A8
    typedef struct packed {
        logic [`PINS_DATA_W-1:0] hi;            // Upper address byte
        logic [`PINS_DATA_W-1:0] port;          // Port number
    } io_addr_t;

    typedef union packed {
        logic [`PINS_ADDR_W-1:0] mem;           // Full memory address
        io_addr_t                io;            // Port view of the same bits
    } addr_word_t;

    // --------------------
    // Cycle kind
    // --------------------
    typedef enum logic [1:0] {
        MEM_RD = 2'd0,
        MEM_WR = 2'd1,
        IO_RD  = 2'd2,
        IO_WR  = 2'd3
    } cycle_kind_t;

    // True for the two I/O kinds, which strobe iorq instead of mreq
    function automatic logic kind_is_io(cycle_kind_t k);
        return (k == IO_RD) || (k == IO_WR);
    endfunction

    // True for the two write kinds
    function automatic logic kind_is_wr(cycle_kind_t k);
        return (k == MEM_WR) || (k == IO_WR);
    endfunction

endpackage

//--- rtl/pins_timing_pkg.sv
/* T-state encoding for one external bus cycle. No M1, refresh or
   interrupt acknowledge states exist. */
package pins_timing_pkg;

    // --------------------
    // Controller states
    // --------------------
    typedef enum logic [2:0] {
        IDLE = 3'd0,        // No cycle, waiting for req
        T1   = 3'd1,        // Address and write data latched
        T2   = 3'd2,        // Strobes asserted, wait_req sampled at the end
        TW   = 3'd3,        // Wait state, strobes held
        T3   = 3'd4,        // Read data on the internal bus
        DONE = 3'd5         // ack high until req drops
    } tstate_t;

    // States where the pins and strobes are live
    function automatic logic strobe_state(tstate_t s);
        return (s == T2) || (s == TW) || (s == T3);
    endfunction

    // States at whose end wait_req is sampled
    function automatic logic wait_sample_state(tstate_t s);
        return (s == T2) || (s == TW);
    endfunction

endpackage

//--- rtl/address_pins.sv
/* Latch is written only by ab_we, so apin holds while the core address moves.
   apin_oe is a plain enable; there are no real tri-states. */
`timescale 1ns/1ns

module address_pins
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ab_we,         // Load the address latch
    input  logic                     ab_pin_oe,     // Drive the address pins
    input  pins_bus_pkg::addr_word_t address,       // Core-side address bus
    output pins_bus_pkg::addr_word_t apin,          // Address pin values
    output logic                     apin_oe        // Address pin output enable
);

    // --------------------
    // Address latch
    // --------------------
    // Updates one edge after ab_we, otherwise keeps the last address
    always_ff @(posedge clk)
    begin
        if (rst)
            apin.mem <= '0;                         // Pins park at zero
        else if (ab_we)
            apin <= address;
    end

    // --------------------
    // Pin enable
    // --------------------
    // Follows the controller without a register
    assign apin_oe = ab_pin_oe;

endmodule

//--- rtl/data_pins.sv
/* One latch serves both directions. A pin read wins over a write from the core
   when both enables are set in the same cycle. */
`timescale 1ns/1ns

module data_pins
(
    input  logic                clk,
    input  logic                rst,
    input  logic                db_we,          // Load latch from the write bus
    input  logic                db_pin_re,      // Load latch from the pins
    input  logic                db_pin_oe,      // Drive the data pins
    input  logic                db_oe,          // Drive the internal read bus
    input  pins_bus_pkg::data_t db_wr,          // Internal write bus
    input  pins_bus_pkg::data_t dpin_in,        // Data pins, input side
    output pins_bus_pkg::data_t dpin_out,       // Data pins, output side
    output pins_bus_pkg::data_t db_rd,          // Internal read bus
    output logic                dpin_oe         // Data pin output enable
);
    import pins_bus_pkg::*;

    data_t data_q;                              // Bidirectional data latch

    // --------------------
    // Data latch
    // --------------------
    always_ff @(posedge clk)
    begin
        if (rst)
            data_q <= '0;
        else if (db_pin_re)                     // Read from the pins first
            data_q <= dpin_in;
        else if (db_we)
            data_q <= db_wr;
    end

    // --------------------
    // Pin side
    // --------------------
    // Latch is always presented; dpin_oe says whether the pins carry it
    assign dpin_out = data_q;
    assign dpin_oe  = db_pin_oe;

    // --------------------
    // Core side
    // --------------------
    // Read bus is zero unless the controller opens it
    always_comb
    begin
        if (db_oe)
            db_rd = data_q;
        else
            db_rd = '0;
    end

endmodule

//--- rtl/bus_cycle_ctrl.sv
/* Runs one cycle per req/ack handshake; req must drop before the next cycle.
   A wait_req that never falls stalls the bus with the strobes held. */
`timescale 1ns/1ns

module bus_cycle_ctrl
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req,        // Core asks for a bus cycle
    input  logic                        wait_req,   // Slow device asks for Tw
    input  pins_bus_pkg::cycle_kind_t   kind,       // Kind of cycle asked for
    input  pins_bus_pkg::data_t         db_rd,      // Internal read bus
    output logic                        ack,        // Cycle finished
    output logic                        mreq,
    output logic                        iorq,
    output logic                        rd,
    output logic                        wr,
    output logic                        ab_we,      // Address latch load
    output logic                        ab_pin_oe,  // Address pin enable
    output logic                        db_we,      // Data latch load from core
    output logic                        db_pin_re,  // Data latch load from pins
    output logic                        db_pin_oe,  // Data pin enable
    output logic                        db_oe,      // Read bus enable
    output pins_bus_pkg::data_t         rdata       // Read data for the core
);
    import pins_bus_pkg::*;
    import pins_timing_pkg::*;

    tstate_t     state;
    tstate_t     state_nxt;
    cycle_kind_t kind_q;                            // Kind of the running cycle
    logic        live;                              // Strobes and pins active
    logic        is_io;
    logic        is_wr;

    // --------------------
    // T-state sequencer
    // --------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
                if (req)
                    state_nxt = T1;                 // Only seen once ack is low
            T1:
                state_nxt = T2;
            T2, TW:
                if (wait_req)
                    state_nxt = TW;                 // Stretch the cycle
                else
                    state_nxt = T3;
            T3:
                state_nxt = DONE;
            DONE:
                if (!req)
                    state_nxt = IDLE;               // Core has seen ack
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Kind is frozen when the cycle starts; later request changes are ignored
    always_ff @(posedge clk)
    begin
        if (rst)
            kind_q <= MEM_RD;
        else if (state == IDLE && req)
            kind_q <= kind;
    end

    // --------------------
    // Strobes
    // --------------------
    assign live  = strobe_state(state);             // T2, Tw and T3
    assign is_io = kind_is_io(kind_q);
    assign is_wr = kind_is_wr(kind_q);

    assign mreq = live && !is_io;
    assign iorq = live && is_io;
    assign rd   = live && !is_wr;
    assign wr   = live && is_wr;

    // --------------------
    // Pin block enables
    // --------------------
    assign ab_we     = (state == T1);               // Address ready from T2
    assign ab_pin_oe = live;
    assign db_we     = (state == T1) && is_wr;      // Write data ready from T2
    assign db_pin_oe = live && is_wr;

    // Pins sampled on the edge into T3, on the last T2 or Tw
    assign db_pin_re = wait_sample_state(state) && !wait_req && !is_wr;
    assign db_oe     = (state == T3) && !is_wr;

    // --------------------
    // Handshake
    // --------------------
    assign ack = (state == DONE);

    // Captured on the edge into DONE and held while ack is high
    always_ff @(posedge clk)
    begin
        if (db_oe)
            rdata <= db_rd;
    end

endmodule

//--- rtl/pin_interface_top.sv
/* Pin-side groups are split into out, enable and in; no tri-state nets exist.
   Only one bus cycle is in flight at a time. */
`timescale 1ns/1ns

module pin_interface_top
(
    input  logic                        clk,
    input  logic                        rst,
    // Core-side handshake
    input  logic                        req,
    input  pins_bus_pkg::cycle_kind_t   kind,
    input  pins_bus_pkg::addr_word_t    addr,
    input  pins_bus_pkg::data_t         wdata,
    output logic                        ack,
    output pins_bus_pkg::data_t         rdata,
    // Pin side
    output pins_bus_pkg::addr_word_t    apin,
    output logic                        apin_oe,
    output pins_bus_pkg::data_t         dpin_out,
    output logic                        dpin_oe,
    output logic                        mreq,
    output logic                        iorq,
    output logic                        rd,
    output logic                        wr,
    input  pins_bus_pkg::data_t         dpin_in,
    input  logic                        wait_req
);
    import pins_bus_pkg::*;

    // --------------------
    // Controller to pin blocks
    // --------------------
    logic  ab_we;
    logic  ab_pin_oe;
    logic  db_we;
    logic  db_pin_re;
    logic  db_pin_oe;
    logic  db_oe;
    data_t db_rd;                                   // Read bus back to controller

    bus_cycle_ctrl bus_cycle_ctrl_inst (
        .clk, .rst, .req, .wait_req, .kind, .db_rd,
        .ack, .mreq, .iorq, .rd, .wr,
        .ab_we, .ab_pin_oe, .db_we, .db_pin_re, .db_pin_oe, .db_oe,
        .rdata
    );

    address_pins address_pins_inst (
        .clk, .rst, .ab_we, .ab_pin_oe,
        .address (addr),                            // Core address straight in
        .apin, .apin_oe
    );

    data_pins data_pins_inst (
        .clk, .rst, .db_we, .db_pin_re, .db_pin_oe, .db_oe,
        .db_wr   (wdata),                           // Core write data straight in
        .dpin_in, .dpin_out, .db_rd, .dpin_oe
    );

endmodule

//--- tb/pin_interface_chk.sv
/* Bound into bus_cycle_ctrl. All properties are disabled while rst is high.
   fail_count holds the number of failed properties so far. */
`timescale 1ns/1ns

module pin_interface_chk
(
    input logic                     clk,
    input logic                     rst,
    input logic                     req,
    input logic                     ack,
    input logic                     mreq,
    input logic                     iorq,
    input logic                     rd,
    input logic                     wr,
    input logic                     db_pin_oe   // Drives dpin_oe at the top
);

    int unsigned fail_count = 0;                // Failed assertions so far

    // --------------------
    // Strobes
    // --------------------
    mreq_iorq_excl: assert property (@(posedge clk) disable iff (rst) !(mreq && iorq))
    else
    begin
        $error("mreq and iorq high together");
        fail_count++;
    end

    rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
    else
    begin
        $error("rd and wr high together");
        fail_count++;
    end

    // Data pins are driven only in a write cycle
    dpin_oe_on_wr: assert property (@(posedge clk) disable iff (rst) db_pin_oe |-> wr)
    else
    begin
        $error("data pins driven outside a write");
        fail_count++;
    end

    // --------------------
    // Handshake
    // --------------------
    ack_held: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
    else
    begin
        $error("ack dropped while req still high");
        fail_count++;
    end

endmodule

bind bus_cycle_ctrl pin_interface_chk chk_inst (
    .clk, .rst, .req, .ack, .mreq, .iorq, .rd, .wr, .db_pin_oe
);

//--- tb/pin_interface_tb.sv
/* Memory and port models hold 256 bytes each; memory is indexed by A7..A0 only.
   Inputs change 1 ns after the rising edge, outputs are checked there too. */
`timescale 1ns/1ns
`include "pins_config.svh"

module pin_interface_tb;
    import pins_bus_pkg::*;

    localparam int WAIT_LIMIT = `PINS_MAX_WAIT + 8;    // Cycles before a wait gives up

    logic        clk;
    logic        rst;
    logic        req;
    cycle_kind_t kind;
    addr_word_t  addr;
    data_t       wdata;
    logic        ack;
    data_t       rdata;
    addr_word_t  apin;
    logic        apin_oe;
    data_t       dpin_out;
    logic        dpin_oe;
    logic        mreq;
    logic        iorq;
    logic        rd;
    logic        wr;
    data_t       dpin_in = '0;
    logic        wait_req;

    data_t       mem_model [0:255];
    data_t       port_model [0:255];

    pin_interface_top DUT (
        .clk, .rst, .req, .kind, .addr, .wdata, .ack, .rdata,
        .apin, .apin_oe, .dpin_out, .dpin_oe, .mreq, .iorq, .rd, .wr,
        .dpin_in, .wait_req
    );

    always #5 clk = ~clk;                               // 10 ns period

    // --------------------
    // Pin model
    // --------------------
    // Answers reads on dpin_in and records writes from dpin_out
    always @(posedge clk)
    begin
        #1;
        if (rd && mreq)
            dpin_in = mem_model[apin.mem[7:0]];
        else if (rd && iorq)
            dpin_in = port_model[apin.io.port];
        else
            dpin_in = '0;
        if (wr && dpin_oe && mreq)
            mem_model[apin.mem[7:0]] = dpin_out;
        else if (wr && dpin_oe && iorq)
            port_model[apin.io.port] = dpin_out;
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_word_t exp, input addr_word_t act);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // --------------------
    // One bus cycle
    // --------------------
    // Called 1 ns after an edge with ack low; returns the same way
    task automatic run_cycle(input cycle_kind_t k, input addr_word_t a, input data_t wd,
                             input int nwait, input int hold, output data_t got);
        int    strobe_cycles;
        int    tmo;
        logic  is_io_k;
        logic  is_wr_k;
        data_t rd_exp;
        is_io_k       = (k == IO_RD) || (k == IO_WR);
        is_wr_k       = (k == MEM_WR) || (k == IO_WR);
        strobe_cycles = 0;
        tmo           = 0;
        if (is_io_k)
            rd_exp = port_model[a.io.port];             // Byte a read must return
        else
            rd_exp = mem_model[a.mem[7:0]];
        req      = 1'b1;
        kind     = k;
        addr     = a;
        wdata    = wd;
        wait_req = (nwait > 0);
        while (!ack)
        begin
            @(posedge clk);
            #1;
            tmo++;
            if (tmo > WAIT_LIMIT)
                report_timeout("ack never rose");
            if (mreq || iorq)                           // T2, Tw or T3
            begin
                strobe_cycles++;
                check_bit("mreq", !is_io_k, mreq);
                check_bit("iorq", is_io_k, iorq);
                check_bit("rd", !is_wr_k, rd);
                check_bit("wr", is_wr_k, wr);
                check_bit("apin_oe", 1'b1, apin_oe);
                check_addr("apin", a, apin);
                check_data("apin.io.port", a.io.port, apin.io.port);
                check_data("apin.io.hi", a.io.hi, apin.io.hi);
                check_bit("dpin_oe", is_wr_k, dpin_oe);
                if (is_wr_k)
                    check_data("dpin_out", wd, dpin_out);
                if (strobe_cycles > nwait)
                    wait_req = 1'b0;                    // Last Tw sampled
            end
        end
        wait_req = 1'b0;
        check_count("strobe cycles", 2 + nwait, strobe_cycles);  // T2, Tw x n, T3
        got = rdata;
        // DONE must hold ack while req stays high
        repeat (hold)
        begin
            @(posedge clk);
            #1;
            check_bit("ack", 1'b1, ack);
            check_bit("mreq", 1'b0, mreq);
            check_bit("iorq", 1'b0, iorq);
            check_bit("rd", 1'b0, rd);
            check_bit("wr", 1'b0, wr);
            check_bit("apin_oe", 1'b0, apin_oe);
            check_bit("dpin_oe", 1'b0, dpin_oe);
            if (!is_wr_k)
                check_data("rdata", rd_exp, rdata);
        end
        req = 1'b0;
        tmo = 0;
        while (ack)
        begin
            @(posedge clk);
            #1;
            tmo++;
            if (tmo > WAIT_LIMIT)
                report_timeout("ack never fell after req dropped");
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_state();
        check_bit("ack", 1'b0, ack);
        check_bit("mreq", 1'b0, mreq);
        check_bit("iorq", 1'b0, iorq);
        check_bit("rd", 1'b0, rd);
        check_bit("wr", 1'b0, wr);
        check_bit("apin_oe", 1'b0, apin_oe);
        check_bit("dpin_oe", 1'b0, dpin_oe);
    endtask

    task automatic test_mem_write();
        addr_word_t a;
        data_t      wd;
        data_t      got;
        a.mem = 16'($urandom);
        wd    = 8'($urandom);
        run_cycle(MEM_WR, a, wd, 0, 0, got);
        check_data("mem_model", wd, mem_model[a.mem[7:0]]);
    endtask

    task automatic test_mem_read();
        addr_word_t a;
        data_t      exp;
        data_t      got;
        a.mem = 16'($urandom);
        exp   = mem_model[a.mem[7:0]];
        run_cycle(MEM_RD, a, '0, 0, 0, got);
        check_data("rdata", exp, got);
    endtask

    task automatic test_io_write_read();
        addr_word_t a;
        data_t      wd;
        data_t      got;
        a.io.port = 8'($urandom);
        a.io.hi   = 8'($urandom);
        wd        = 8'($urandom);
        run_cycle(IO_WR, a, wd, 0, 0, got);
        check_data("port_model", wd, port_model[a.io.port]);
        a.io.hi = ~a.io.hi;                             // Same port, other high byte
        run_cycle(IO_RD, a, '0, 0, 0, got);
        check_data("rdata", wd, got);
    endtask

    task automatic test_wait_states();
        addr_word_t a;
        data_t      wd;
        data_t      got;
        int         nwait;
        repeat (4)
        begin
            a.mem = 16'($urandom);
            wd    = 8'($urandom);
            nwait = 1 + int'($urandom % 8);
            run_cycle(MEM_WR, a, wd, nwait, 0, got);
            nwait = 1 + int'($urandom % 8);
            run_cycle(MEM_RD, a, '0, nwait, 0, got);
            check_data("rdata", wd, got);
        end
    endtask

    task automatic test_back_pressure();
        addr_word_t a;
        data_t      exp;
        data_t      got;
        a.mem = 16'($urandom);
        exp   = mem_model[a.mem[7:0]];
        run_cycle(MEM_RD, a, '0, 0, 6, got);            // req held 6 cycles past ack
        check_data("rdata", exp, got);
        test_mem_read();                                // Next cycle still starts
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        void'($urandom(32'h150f));
        clk      = 1'b0;
        rst      = 1'b1;
        req      = 1'b0;
        kind     = MEM_RD;
        addr     = '0;
        wdata    = '0;
        wait_req = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            mem_model[i]  = 8'($urandom);
            port_model[i] = 8'($urandom);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_mem_write();
        test_mem_read();
        test_io_write_read();
        test_wait_states();
        test_back_pressure();
        @(posedge clk);
        #1;
        if (DUT.bus_cycle_ctrl_inst.chk_inst.fail_count == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("Bus assertions failed during the run");
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
rtl/pins_bus_pkg.sv
rtl/pins_timing_pkg.sv
rtl/address_pins.sv
rtl/data_pins.sv
rtl/bus_cycle_ctrl.sv
rtl/pin_interface_top.sv
tb/pin_interface_chk.sv
tb/pin_interface_tb.sv

//--- Makefile
SIM      = verilator
TOP      = pin_interface_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
RUN_ARGS = +verilator+error+limit+1000
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass message
run: compile
	@out="$$($(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
